/* cnn_pkg.sv */
`default_nettype none

package cnn_pkg;

  localparam int DATA_W      = 32;
  localparam int BYTE_W      = 8;
  localparam int WORD_BYTES  = DATA_W / BYTE_W;
  localparam int NUM_FILT    = 8;
  localparam int K_DIM       = 5;
  localparam int K_TAPS      = 25;
  localparam int FM_ROWS     = 6;
  localparam int FM_COLS     = 8;
  localparam int FM_BYTES    = FM_ROWS * FM_COLS;
  localparam int FM_WORDS    = 12;
  localparam int W_BYTES     = NUM_FILT * K_TAPS;
  localparam int W_WORDS     = 50;
  localparam int OUT_WORDS   = 4;
  localparam int OUT_CREDITS = 2;
  localparam int QUANT_SHIFT = 7;
  localparam int ACC_W       = 32;

  localparam int NUM_WIN  = 8;  // 2x4 output block
  localparam int POOL_WIN = 4;  // results per pooled byte
  localparam int POOL_LAT = 3;  // window load to pool step

  // address and counter widths
  localparam int FM_AW  = $clog2(FM_WORDS);
  localparam int W_AW   = $clog2(W_WORDS);
  localparam int OUT_AW = $clog2(OUT_WORDS);
  localparam int CRED_W = $clog2(OUT_CREDITS + 1);

  // controller states
  localparam logic [2:0] ST_IDLE  = 3'd0;
  localparam logic [2:0] ST_LOAD  = 3'd1;
  localparam logic [2:0] ST_WIN   = 3'd2;
  localparam logic [2:0] ST_FLUSH = 3'd3;
  localparam logic [2:0] ST_DRAIN = 3'd4;

  // memory word, whole or as bytes (byte 0 is the msb)
  typedef union packed {
    logic [DATA_W-1:0]                   word;
    logic [0:WORD_BYTES-1][BYTE_W-1:0]   bytes;
  } mem_word_u;

endpackage

`default_nettype wire

/* cnn_tile_top.sv */
`default_nettype none

module cnn_tile_top (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic                       i_start,
  input  wire logic [cnn_pkg::DATA_W-1:0] i_fm_rdata,
  input  wire logic [cnn_pkg::DATA_W-1:0] i_w_rdata,
  input  wire logic                       i_out_credit,
  output logic                            o_busy,
  output logic                            o_done,
  output logic                            o_fm_rd,
  output logic [cnn_pkg::FM_AW-1:0]       o_fm_addr,
  output logic                            o_w_rd,
  output logic [cnn_pkg::W_AW-1:0]        o_w_addr,
  output logic                            o_out_valid,
  output logic [cnn_pkg::OUT_AW-1:0]      o_out_addr,
  output logic [cnn_pkg::DATA_W-1:0]      o_out_data
);

  logic                           fm_fill;
  logic                           w_fill;
  logic [cnn_pkg::W_AW-1:0]       fill_idx;
  logic                           win_load;
  logic                           win_row;
  logic [1:0]                     win_col;
  logic                           pe_capture;
  logic                           pool_step;
  logic                           drain;
  logic                           out_done;
  logic [cnn_pkg::K_TAPS-1:0][cnn_pkg::BYTE_W-1:0]   window;
  logic [cnn_pkg::W_BYTES-1:0][cnn_pkg::BYTE_W-1:0]  weights;
  logic [cnn_pkg::NUM_FILT-1:0][cnn_pkg::BYTE_W-1:0] pe_results;

  tile_ctrl u_tile_ctrl (
    .clk, .rst, .i_start, .i_out_done(out_done),
    .o_busy, .o_done, .o_fm_rd, .o_fm_addr, .o_w_rd, .o_w_addr,
    .o_fm_fill(fm_fill), .o_w_fill(w_fill), .o_fill_idx(fill_idx),
    .o_win_load(win_load), .o_win_row(win_row), .o_win_col(win_col),
    .o_pe_capture(pe_capture), .o_pool_step(pool_step), .o_drain(drain)
  );

  fmap_cache u_fmap_cache (
    .clk, .rst, .i_fill(fm_fill), .i_fill_idx(fill_idx), .i_fill_data(i_fm_rdata),
    .i_win_load(win_load), .i_win_row(win_row), .i_win_col(win_col), .o_window(window)
  );

  weight_cache u_weight_cache (
    .clk, .rst, .i_fill(w_fill), .i_fill_idx(fill_idx), .i_fill_data(i_w_rdata),
    .o_weights(weights)
  );

  // one pe per filter, all share the window
  for (genvar g = 0; g < cnn_pkg::NUM_FILT; g++) begin : g_pe
    conv_pe u_conv_pe (
      .clk, .rst, .i_window(window),
      .i_weights(weights[g * cnn_pkg::K_TAPS +: cnn_pkg::K_TAPS]),
      .o_result(pe_results[g])
    );
  end

  pool_writer u_pool_writer (
    .clk, .rst, .i_pe_results(pe_results), .i_capture(pe_capture),
    .i_pool_step(pool_step), .i_drain(drain), .i_out_credit,
    .o_out_valid, .o_out_addr, .o_out_data, .o_out_done(out_done)
  );

endmodule

`default_nettype wire

/* conv_pe.sv */
`default_nettype none

module conv_pe (
  input  wire logic                                         clk,
  input  wire logic                                         rst,
  input  wire logic [cnn_pkg::K_TAPS-1:0][cnn_pkg::BYTE_W-1:0] i_window,
  input  wire logic [cnn_pkg::K_TAPS-1:0][cnn_pkg::BYTE_W-1:0] i_weights,
  output logic [cnn_pkg::BYTE_W-1:0]                        o_result
);

  logic signed [cnn_pkg::ACC_W-1:0] acc;
  logic signed [cnn_pkg::ACC_W-1:0] scaled;
  logic [cnn_pkg::BYTE_W-1:0]       quant;

  always_comb begin
    acc = '0;
    for (int t = 0; t < cnn_pkg::K_TAPS; t++) begin
      // unsigned pixel times signed weight
      acc = acc + $signed({1'b0, i_window[t]}) * $signed(i_weights[t]);
    end
    scaled = acc[cnn_pkg::ACC_W-1] ? '0 : (acc >>> cnn_pkg::QUANT_SHIFT);  // relu first
    // saturate to one byte
    quant = (|scaled[cnn_pkg::ACC_W-1:cnn_pkg::BYTE_W]) ? '1 : scaled[cnn_pkg::BYTE_W-1:0];
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_result <= '0;
    end else begin
      o_result <= quant;
    end
  end

endmodule

`default_nettype wire

/* fmap_cache.sv */
`default_nettype none

module fmap_cache (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic                       i_fill,
  input  wire logic [cnn_pkg::W_AW-1:0]   i_fill_idx,
  input  wire cnn_pkg::mem_word_u         i_fill_data,
  input  wire logic                       i_win_load,
  input  wire logic                       i_win_row,
  input  wire logic [1:0]                 i_win_col,
  output logic [cnn_pkg::K_TAPS-1:0][cnn_pkg::BYTE_W-1:0] o_window
);

  // tile store, byte r*8+c is row r column c
  logic [cnn_pkg::BYTE_W-1:0] store [cnn_pkg::FM_BYTES];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int k = 0; k < cnn_pkg::FM_BYTES; k++) begin
        store[k] <= '0;
      end
    end else if (i_fill) begin
      for (int b = 0; b < cnn_pkg::WORD_BYTES; b++) begin
        store[int'(i_fill_idx) * cnn_pkg::WORD_BYTES + b] <= i_fill_data.bytes[b];
      end
    end
  end

  // 5x5 block with its top-left corner at (row, col)
  always_ff @(posedge clk) begin
    if (i_win_load) begin
      for (int i = 0; i < cnn_pkg::K_DIM; i++) begin
        for (int j = 0; j < cnn_pkg::K_DIM; j++) begin
          o_window[i * cnn_pkg::K_DIM + j] <=
            store[(int'(i_win_row) + i) * cnn_pkg::FM_COLS + int'(i_win_col) + j];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* pool_writer.sv */
`default_nettype none

module pool_writer (
  input  wire logic                                           clk,
  input  wire logic                                           rst,
  input  wire logic [cnn_pkg::NUM_FILT-1:0][cnn_pkg::BYTE_W-1:0] i_pe_results,
  input  wire logic                                           i_capture,
  input  wire logic                                           i_pool_step,
  input  wire logic                                           i_drain,
  input  wire logic                                           i_out_credit,
  output logic                                                o_out_valid,
  output logic [cnn_pkg::OUT_AW-1:0]                          o_out_addr,
  output cnn_pkg::mem_word_u                                  o_out_data,
  output logic                                                o_out_done
);

  logic [cnn_pkg::BYTE_W-1:0] win_q [cnn_pkg::NUM_FILT][cnn_pkg::POOL_WIN];
  logic [cnn_pkg::BYTE_W-1:0] pooled [cnn_pkg::NUM_FILT];
  logic [cnn_pkg::BYTE_W-1:0] stage_q [cnn_pkg::OUT_WORDS * cnn_pkg::WORD_BYTES];
  logic [cnn_pkg::CRED_W-1:0] credits_q;
  logic [cnn_pkg::OUT_AW:0]   sent_q;

  // last four results of each filter, oldest at 0
  always_ff @(posedge clk) begin
    if (i_capture) begin
      for (int f = 0; f < cnn_pkg::NUM_FILT; f++) begin
        win_q[f][cnn_pkg::POOL_WIN-1] <= i_pe_results[f];
        for (int k = 1; k < cnn_pkg::POOL_WIN; k++) begin
          win_q[f][k-1] <= win_q[f][k];
        end
      end
    end
  end

  always_comb begin
    for (int f = 0; f < cnn_pkg::NUM_FILT; f++) begin
      pooled[f] = win_q[f][0];
      for (int k = 1; k < cnn_pkg::POOL_WIN; k++) begin
        if (win_q[f][k] > pooled[f]) pooled[f] = win_q[f][k];
      end
    end
  end

  // new group enters the upper half, older group moves down
  always_ff @(posedge clk) begin
    if (i_pool_step) begin
      for (int f = 0; f < cnn_pkg::NUM_FILT; f++) begin
        stage_q[f]                    <= stage_q[f + cnn_pkg::NUM_FILT];
        stage_q[f + cnn_pkg::NUM_FILT] <= pooled[f];
      end
    end
  end

  assign o_out_valid = i_drain && (sent_q < cnn_pkg::OUT_WORDS) && (credits_q != '0);
  assign o_out_addr  = sent_q[cnn_pkg::OUT_AW-1:0];
  assign o_out_done  = (sent_q == cnn_pkg::OUT_WORDS);

  always_comb begin
    for (int b = 0; b < cnn_pkg::WORD_BYTES; b++) begin
      o_out_data.bytes[b] = stage_q[int'(o_out_addr) * cnn_pkg::WORD_BYTES + b];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      credits_q <= cnn_pkg::OUT_CREDITS[cnn_pkg::CRED_W-1:0];
      sent_q    <= '0;
    end else begin
      case ({o_out_valid, i_out_credit})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: credits_q <= credits_q;  // none or send plus return
      endcase
      if (!i_drain) sent_q <= '0;  // rearm for the next tile
      else if (o_out_valid) sent_q <= sent_q + 1'b1;
    end
  end

  // out of credit with none coming back, so nothing goes out next cycle
  a_no_send_dry: assert property (@(posedge clk) disable iff (rst)
    (credits_q == '0) && !i_out_credit |=> !o_out_valid);

  // receiver must not hand back more than it was given
  a_credit_cap: assert property (@(posedge clk) disable iff (rst)
    credits_q <= cnn_pkg::OUT_CREDITS);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_cnn_tile -f sim.f \
  && ./obj_dir/Vtb_cnn_tile | tee /dev/stderr | grep -q "All tests passed" \
  && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }

/* sim.f */
cnn_pkg.sv
tile_ctrl.sv
fmap_cache.sv
weight_cache.sv
conv_pe.sv
pool_writer.sv
cnn_tile_top.sv
tb_cnn_tile.sv

/* tb_cnn_tile.sv */
`default_nettype none

module tb_cnn_tile;

  logic                              clk;
  logic                              rst;
  logic                              i_start;
  logic [cnn_pkg::DATA_W-1:0]        i_fm_rdata;
  logic [cnn_pkg::DATA_W-1:0]        i_w_rdata;
  logic                              i_out_credit;
  logic                              o_busy;
  logic                              o_done;
  logic                              o_fm_rd;
  logic [cnn_pkg::FM_AW-1:0]         o_fm_addr;
  logic                              o_w_rd;
  logic [cnn_pkg::W_AW-1:0]          o_w_addr;
  logic                              o_out_valid;
  logic [cnn_pkg::OUT_AW-1:0]        o_out_addr;
  logic [cnn_pkg::DATA_W-1:0]        o_out_data;

  logic [cnn_pkg::DATA_W-1:0] fm_mem [cnn_pkg::FM_WORDS];
  logic [cnn_pkg::DATA_W-1:0] w_mem [cnn_pkg::W_WORDS];
  logic                       fm_pend;
  logic [cnn_pkg::FM_AW-1:0]  fm_pend_addr;
  logic                       w_pend;
  logic [cnn_pkg::W_AW-1:0]   w_pend_addr;
  logic [cnn_pkg::OUT_AW-1:0] rx_addr [$];
  cnn_pkg::mem_word_u         rx_data [$];
  int                         owed_q [$];   // words awaiting credit when each word left
  int                         due [$];      // cycle at which each credit goes back
  int                         cyc;
  int                         credit_delay;
  int                         sent_cnt;
  int                         ret_cnt;
  int                         done_cnt;
  int                         w_reads;
  int                         err_cnt;
  int                         test_cnt;
  int                         bad_tests;
  int                         seed;
  bit                         timed_out;

  cnn_tile_top u_cnn_tile_top (
    .clk, .rst, .i_start, .i_fm_rdata, .i_w_rdata, .i_out_credit,
    .o_busy, .o_done, .o_fm_rd, .o_fm_addr, .o_w_rd, .o_w_addr,
    .o_out_valid, .o_out_addr, .o_out_data
  );

  always #2 clk = ~clk;

  // read data and credit pulses, just after the edge
  always @(posedge clk) begin
    #1;
    cyc = cyc + 1;
    if (fm_pend) i_fm_rdata = fm_mem[fm_pend_addr];
    if (w_pend) i_w_rdata = w_mem[w_pend_addr];
    if (due.size() > 0 && due[0] <= cyc) begin
      void'(due.pop_front());
      i_out_credit = 1'b1;
    end else begin
      i_out_credit = 1'b0;
    end
  end

  // outputs sampled mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      fm_pend      = o_fm_rd;
      fm_pend_addr = o_fm_addr;
      w_pend       = o_w_rd;
      w_pend_addr  = o_w_addr;
      if (o_w_rd) w_reads++;
      if (o_out_valid) begin
        if (sent_cnt - ret_cnt >= cnn_pkg::OUT_CREDITS) begin
          $display("at %0t a word was sent with no credit left", $time);
          err_cnt++;
        end
        owed_q.push_back(sent_cnt - ret_cnt);
        rx_addr.push_back(o_out_addr);
        rx_data.push_back(o_out_data);
        due.push_back(cyc + credit_delay);
        sent_cnt++;
      end
      if (i_out_credit) ret_cnt++;
      if (o_done) begin
        done_cnt++;
        if (rx_data.size() != cnn_pkg::OUT_WORDS) begin
          $display("at %0t done pulsed after only %0d words", $time, rx_data.size());
          err_cnt++;
        end
      end
    end
  end

  task automatic check_word(input string what, input cnn_pkg::mem_word_u got,
                            input cnn_pkg::mem_word_u exp);
    if (got.word !== exp.word) begin
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got.word, exp.word);
      err_cnt++;
    end
  endtask

  task automatic check_addr(input string what, input logic [cnn_pkg::OUT_AW-1:0] got,
                            input logic [cnn_pkg::OUT_AW-1:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  function automatic logic [7:0] fm_byte(input int k);
    return fm_mem[k / 4][31 - 8 * (k % 4) -: 8];
  endfunction

  function automatic logic [7:0] w_byte(input int k);
    return w_mem[k / 4][31 - 8 * (k % 4) -: 8];
  endfunction

  // one filter at one window position, relu then shift and clamp
  function automatic logic [7:0] conv_ref(input int f, input int r, input int c);
    int acc;
    int pix;
    logic signed [7:0] wt;
    acc = 0;
    for (int i = 0; i < cnn_pkg::K_DIM; i++) begin
      for (int j = 0; j < cnn_pkg::K_DIM; j++) begin
        pix = int'(fm_byte((r + i) * cnn_pkg::FM_COLS + c + j));
        wt  = w_byte(f * cnn_pkg::K_TAPS + i * cnn_pkg::K_DIM + j);
        acc = acc + pix * int'(wt);
      end
    end
    if (acc < 0) acc = 0;
    acc = acc >>> cnn_pkg::QUANT_SHIFT;
    if (acc > 255) acc = 255;
    return acc[7:0];
  endfunction

  // pooled byte k is group k/8, filter k%8
  function automatic cnn_pkg::mem_word_u expect_word(input int n);
    cnn_pkg::mem_word_u w;
    logic [7:0] best;
    logic [7:0] v;
    int k;
    for (int b = 0; b < 4; b++) begin
      k = 4 * n + b;
      best = '0;
      for (int p = 0; p < 4; p++) begin
        v = conv_ref(k % 8, p / 2, 2 * (k / 8) + p % 2);
        if (v > best) best = v;
      end
      w.word[31 - 8 * b -: 8] = best;
    end
    return w;
  endfunction

  task automatic set_fm_byte(input int k, input logic [7:0] v);
    fm_mem[k / 4][31 - 8 * (k % 4) -: 8] = v;
  endtask

  task automatic set_w_byte(input int k, input logic [7:0] v);
    w_mem[k / 4][31 - 8 * (k % 4) -: 8] = v;
  endtask

  task automatic fill_const(input logic [7:0] pix, input logic [7:0] wt);
    for (int k = 0; k < cnn_pkg::FM_WORDS; k++) fm_mem[k] = {4{pix}};
    for (int k = 0; k < cnn_pkg::W_WORDS; k++) w_mem[k] = {4{wt}};
  endtask

  task automatic fill_random();
    for (int k = 0; k < cnn_pkg::FM_WORDS; k++) fm_mem[k] = $random(seed);
    for (int k = 0; k < cnn_pkg::W_WORDS; k++) w_mem[k] = $random(seed);
  endtask

  task automatic pulse_start();
    @(posedge clk);
    #1 i_start = 1'b1;
    @(posedge clk);
    #1 i_start = 1'b0;
  endtask

  task automatic wait_for_done(input int target, input int limit);
    int n;
    n = 0;
    while (done_cnt < target && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (done_cnt < target) begin
      $display("timeout: no done pulse within %0d cycles", limit);
      timed_out = 1'b1;
      err_cnt++;
    end
  endtask

  task automatic wait_for_credits(input int limit);
    int n;
    n = 0;
    while (ret_cnt < sent_cnt && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (ret_cnt < sent_cnt) begin
      $display("timeout: credits not all returned within %0d cycles", limit);
      timed_out = 1'b1;
      err_cnt++;
    end
  endtask

  // one tile from start to done, then the words against the model
  task automatic run_tile(input int delay, input bit extra_start);
    int done0;
    logic [cnn_pkg::OUT_AW-1:0] a;
    credit_delay = delay;
    rx_addr.delete();
    rx_data.delete();
    owed_q.delete();
    w_reads = 0;
    done0 = done_cnt;
    pulse_start();
    if (extra_start) begin
      repeat (20) @(negedge clk);
      check_flag("busy before second start", o_busy, 1'b1);
      pulse_start();  // must not restart the load
    end
    wait_for_done(done0 + 1, 500);
    if (!timed_out) wait_for_credits(500);
    if (timed_out) return;
    @(negedge clk);
    if (done_cnt != done0 + 1) begin
      $display("FAILED at %0t: done pulsed %0d times for one tile", $time, done_cnt - done0);
      err_cnt++;
    end
    if (w_reads != cnn_pkg::W_WORDS) begin
      $display("FAILED at %0t: %0d weight reads for one tile, expected %0d", $time, w_reads,
               cnn_pkg::W_WORDS);
      err_cnt++;
    end
    check_flag("busy after done", o_busy, 1'b0);
    if (rx_data.size() != cnn_pkg::OUT_WORDS) begin
      $display("FAILED at %0t: %0d output words for one tile, expected %0d", $time,
               rx_data.size(), cnn_pkg::OUT_WORDS);
      err_cnt++;
    end else begin
      for (int n = 0; n < cnn_pkg::OUT_WORDS; n++) begin
        a = n[cnn_pkg::OUT_AW-1:0];
        check_addr("output address", rx_addr[n], a);
        check_word("output word", rx_data[n], expect_word(n));
      end
    end
  endtask

  task automatic report(input string name, input int errs0);
    test_cnt++;
    if (err_cnt == errs0) begin
      $display("test %s: pass", name);
    end else begin
      bad_tests++;
      $display("test %s: fail with %0d errors", name, err_cnt - errs0);
    end
  endtask

  task automatic test_reset_idle();
    int errs0;
    errs0 = err_cnt;
    @(negedge clk);
    check_flag("o_busy after reset", o_busy, 1'b0);
    check_flag("o_done after reset", o_done, 1'b0);
    check_flag("o_out_valid after reset", o_out_valid, 1'b0);
    check_flag("o_fm_rd after reset", o_fm_rd, 1'b0);
    check_flag("o_w_rd after reset", o_w_rd, 1'b0);
    fill_const(8'h02, 8'h40);
    run_tile(60, 1'b0);
    // both reset credits spent before any came back
    if (!timed_out && (owed_q.size() < 2 || owed_q[0] != 0 || owed_q[1] != 1)) begin
      $display("the first two words did not go out on the reset credits");
      err_cnt++;
    end
    report("reset_idle", errs0);
  endtask

  task automatic test_uniform();
    int errs0;
    errs0 = err_cnt;
    fill_const(8'h01, 8'h40);
    run_tile(1, 1'b0);
    for (int n = 0; n < rx_data.size(); n++) check_word("uniform word", rx_data[n], 32'h0C0C0C0C);
    report("uniform", errs0);
  endtask

  task automatic test_relu();
    int errs0;
    int v;
    errs0 = err_cnt;
    for (int k = 0; k < cnn_pkg::FM_BYTES; k++) begin
      v = (k * 7 + 3) % 200;
      set_fm_byte(k, v[7:0]);
    end
    for (int k = 0; k < cnn_pkg::W_BYTES; k++) begin
      v = (k < 4 * cnn_pkg::K_TAPS) ? -(k % 5 + 1) : k % 13 + 2;  // filters 0..3 negative
      set_w_byte(k, v[7:0]);
    end
    run_tile(3, 1'b0);
    if (rx_data.size() == cnn_pkg::OUT_WORDS) begin
      check_word("relu word 0", rx_data[0], 32'h0);
      check_word("relu word 2", rx_data[2], 32'h0);
    end
    report("relu", errs0);
  endtask

  task automatic test_saturate();
    int errs0;
    errs0 = err_cnt;
    fill_const(8'hFF, 8'h7F);
    run_tile(2, 1'b0);
    for (int n = 0; n < rx_data.size(); n++) begin
      check_word("saturated word", rx_data[n], 32'hFFFFFFFF);
    end
    report("saturate", errs0);
  endtask

  task automatic test_random_slow();
    int errs0;
    errs0 = err_cnt;
    fill_random();
    run_tile(30, 1'b0);
    report("random_slow_credit", errs0);
  endtask

  task automatic test_restart();
    int errs0;
    errs0 = err_cnt;
    fill_random();
    run_tile(5, 1'b1);
    if (!timed_out) begin
      fill_random();  // new data for the second tile
      run_tile(1, 1'b0);
    end
    report("start_while_busy", errs0);
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    i_start      = 1'b0;
    i_fm_rdata   = '0;
    i_w_rdata    = '0;
    i_out_credit = 1'b0;
    fm_pend      = 1'b0;
    fm_pend_addr = '0;
    w_pend       = 1'b0;
    w_pend_addr  = '0;
    cyc          = 0;
    credit_delay = 1;
    sent_cnt     = 0;
    ret_cnt      = 0;
    done_cnt     = 0;
    w_reads      = 0;
    err_cnt      = 0;
    test_cnt     = 0;
    bad_tests    = 0;
    timed_out    = 1'b0;
    seed         = 32'h7ec51762;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    test_reset_idle();
    if (!timed_out) test_uniform();
    if (!timed_out) test_relu();
    if (!timed_out) test_saturate();
    if (!timed_out) test_random_slow();
    if (!timed_out) test_restart();
    $display("%0d tests run, %0d with errors, %0d errors in total", test_cnt, bad_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tile_ctrl.sv */
`default_nettype none

module tile_ctrl (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic                       i_start,
  input  wire logic                       i_out_done,
  output logic                            o_busy,
  output logic                            o_done,
  output logic                            o_fm_rd,
  output logic [cnn_pkg::FM_AW-1:0]       o_fm_addr,
  output logic                            o_w_rd,
  output logic [cnn_pkg::W_AW-1:0]        o_w_addr,
  output logic                            o_fm_fill,
  output logic                            o_w_fill,
  output logic [cnn_pkg::W_AW-1:0]        o_fill_idx,
  output logic                            o_win_load,
  output logic                            o_win_row,
  output logic [1:0]                      o_win_col,
  output logic                            o_pe_capture,
  output logic                            o_pool_step,
  output logic                            o_drain
);

  logic [2:0]                      state_q;
  logic [cnn_pkg::W_AW-1:0]        step_q;
  logic [1:0]                      cap_pipe_q;   // window reg, then pe reg
  logic [cnn_pkg::POOL_LAT-1:0]    pool_pipe_q;
  logic                            group_end;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= cnn_pkg::ST_IDLE;
      step_q  <= '0;
    end else begin
      case (state_q)
        cnn_pkg::ST_IDLE: begin
          if (i_start) begin
            state_q <= cnn_pkg::ST_LOAD;
            step_q  <= '0;
          end
        end
        cnn_pkg::ST_LOAD: begin  // one extra cycle for the last fill
          if (step_q == cnn_pkg::W_WORDS) begin
            state_q <= cnn_pkg::ST_WIN;
            step_q  <= '0;
          end else begin
            step_q <= step_q + 1'b1;
          end
        end
        cnn_pkg::ST_WIN: begin
          if (step_q == cnn_pkg::NUM_WIN - 1) begin
            state_q <= cnn_pkg::ST_FLUSH;
            step_q  <= '0;
          end else begin
            step_q <= step_q + 1'b1;
          end
        end
        cnn_pkg::ST_FLUSH: begin  // let the last pool step land
          if (step_q == cnn_pkg::POOL_LAT - 1) begin
            state_q <= cnn_pkg::ST_DRAIN;
            step_q  <= '0;
          end else begin
            step_q <= step_q + 1'b1;
          end
        end
        cnn_pkg::ST_DRAIN: begin
          if (i_out_done) state_q <= cnn_pkg::ST_IDLE;
        end
        default: state_q <= cnn_pkg::ST_IDLE;
      endcase
    end
  end

  assign o_busy   = (state_q != cnn_pkg::ST_IDLE);
  assign o_w_rd   = (state_q == cnn_pkg::ST_LOAD) && (step_q < cnn_pkg::W_WORDS);
  assign o_fm_rd  = (state_q == cnn_pkg::ST_LOAD) && (step_q < cnn_pkg::FM_WORDS);
  assign o_w_addr  = step_q;
  assign o_fm_addr = step_q[cnn_pkg::FM_AW-1:0];

  // window order (0,0) (0,1) (1,0) (1,1) (0,2) (0,3) (1,2) (1,3)
  assign o_win_load = (state_q == cnn_pkg::ST_WIN);
  assign o_win_row  = step_q[1];
  assign o_win_col  = {step_q[2], step_q[0]};
  assign group_end  = o_win_load && (step_q[1:0] == 2'b11);

  assign o_drain = (state_q == cnn_pkg::ST_DRAIN);
  assign o_done  = o_drain && i_out_done;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cap_pipe_q  <= '0;
      pool_pipe_q <= '0;
      o_fm_fill   <= 1'b0;
      o_w_fill    <= 1'b0;
    end else begin
      cap_pipe_q  <= {cap_pipe_q[0], o_win_load};
      pool_pipe_q <= {pool_pipe_q[cnn_pkg::POOL_LAT-2:0], group_end};
      o_fm_fill   <= o_fm_rd;  // data returns one cycle after the read
      o_w_fill    <= o_w_rd;
    end
  end

  always_ff @(posedge clk) begin
    o_fill_idx <= o_w_addr;  // both reads share the step index
  end

  assign o_pe_capture = cap_pipe_q[1];
  assign o_pool_step  = pool_pipe_q[cnn_pkg::POOL_LAT-1];

  a_rd_addr_range: assert property (@(posedge clk) disable iff (rst)
    (o_fm_rd -> (o_fm_addr < cnn_pkg::FM_WORDS)) && (o_w_rd -> (o_w_addr < cnn_pkg::W_WORDS)));

endmodule

`default_nettype wire

/* weight_cache.sv */
`default_nettype none

module weight_cache (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic                       i_fill,
  input  wire logic [cnn_pkg::W_AW-1:0]   i_fill_idx,
  input  wire cnn_pkg::mem_word_u         i_fill_data,
  output logic [cnn_pkg::W_BYTES-1:0][cnn_pkg::BYTE_W-1:0] o_weights
);

  // byte f*25+i*5+j is filter f, kernel row i, column j
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_weights <= '0;
    end else if (i_fill) begin
      for (int b = 0; b < cnn_pkg::WORD_BYTES; b++) begin
        o_weights[int'(i_fill_idx) * cnn_pkg::WORD_BYTES + b] <= i_fill_data.bytes[b];
      end
    end
  end

endmodule

`default_nettype wire
